/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= all.f
TOP        ?= tb_gaussian_blur
RTL_TOP    ?= gaussian_blur_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert
PASS_TEXT  ?= Result: PASSED

RTL_SRCS = $(filter src/%.sv,$(shell cat $(FILELIST)))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Output goes to the terminal and is searched for the pass line
sim: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
src/blur_geom_pkg.sv
src/blur_ctrl_pkg.sv
src/blur_ctrl.sv
src/row_window.sv
src/gauss3_kernel.sv
src/strip_merge.sv
src/gaussian_blur_top.sv
test/gaussian_blur_assert.sv
test/tb_gaussian_blur.sv

/* src/blur_ctrl.sv */
module blur_ctrl #(
  parameter int STRIP_COUNT = 4,
  parameter int IMG_ROWS    = 12
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  output logic                     done,
  output blur_geom_pkg::row_addr_t img_addr,
  output blur_geom_pkg::col_t      col,
  output logic                     win_clear,
  output logic                     row_shift,
  output logic                     zero_row,
  output blur_geom_pkg::row_addr_t blur_addr_r,
  output logic                     rd_valid
);
  import blur_geom_pkg::*;
  import blur_ctrl_pkg::*;

  blur_state_t state;
  blur_state_t state_next;
  row_addr_t   step;
  logic        rows_end;
  logic        drain_end;
  logic        last_strip;
  logic        accept;

  assign rows_end   = (step == row_addr_t'(IMG_ROWS));
  assign drain_end  = (step == row_addr_t'(DRAIN_CYCLES - 1));
  assign last_strip = (col == col_t'(STRIP_COUNT - 1));
  assign accept     = (state == ST_IDLE) && start;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (start) begin
          state_next = ST_COL_START;
        end
      end
      ST_COL_START: begin
        state_next = ST_ROWS;
      end
      ST_ROWS: begin
        // Last step pushes the zero row below the image
        if (rows_end) begin
          state_next = ST_DRAIN;
        end
      end
      ST_DRAIN: begin
        if (drain_end) begin
          state_next = last_strip ? ST_IDLE : ST_COL_START;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Row steps in ST_ROWS, drain cycles in ST_DRAIN
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      step <= '0;
    end else if (state != state_next) begin
      step <= '0;
    end else if (state == ST_ROWS || state == ST_DRAIN) begin
      step <= step + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col <= '0;
    end else if (accept) begin
      col <= '0;
    end else if (state == ST_DRAIN && drain_end && !last_strip) begin
      col <= col + 1'b1;
    end
  end

  // Set on the way into ST_IDLE, so the last write has already landed
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else if (accept) begin
      done <= 1'b0;
    end else if (state == ST_DRAIN && drain_end && last_strip) begin
      done <= 1'b1;
    end
  end

  assign win_clear = (state == ST_COL_START);
  assign img_addr  = (state == ST_ROWS && !rows_end) ? step : '0;

  // Step k lands in the window one cycle later, row k-1 is read back for merging
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_shift   <= 1'b0;
      zero_row    <= 1'b0;
      rd_valid    <= 1'b0;
      blur_addr_r <= '0;
    end else begin
      row_shift <= (state == ST_ROWS);
      zero_row  <= (state == ST_ROWS) && rows_end;
      rd_valid  <= (state == ST_ROWS) && (step != '0);
      if (state == ST_ROWS && step != '0) begin
        blur_addr_r <= step - 1'b1;
      end
    end
  end

endmodule

/* src/blur_ctrl_pkg.sv */
package blur_ctrl_pkg;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COL_START,
    ST_ROWS,
    ST_DRAIN
  } blur_state_t;

  // Covers the shift, read and write stages behind the last row step
  localparam int DRAIN_CYCLES = 3;

endpackage

/* src/blur_geom_pkg.sv */
package blur_geom_pkg;

  localparam int STRIP_PIX = 16;

  typedef logic [7:0] pixel_t;

  // One strip of the row, pixel 0 in the top byte
  typedef logic [STRIP_PIX*8-1:0] strip_t;

  // Strip with one neighbour pixel on each side
  typedef logic [(STRIP_PIX+2)*8-1:0] halo_t;

  typedef logic [8:0] row_addr_t;
  typedef logic [5:0] col_t;

  // 3x3 Gaussian weights, they sum to 16
  localparam int KERNEL_W [3][3] = '{
    '{1, 2, 1},
    '{2, 4, 2},
    '{1, 2, 1}
  };

  localparam int KERNEL_SHIFT = 4;
  localparam int KERNEL_ROUND = 8;

endpackage

/* src/gauss3_kernel.sv */
module gauss3_kernel (
  input  blur_geom_pkg::halo_t [2:0] win_rows,
  output blur_geom_pkg::strip_t      blur_strip
);
  import blur_geom_pkg::*;

  localparam int STRIP_W = $bits(strip_t);

  // Holds 16 * 255 plus the rounding term
  typedef logic [11:0] acc_t;

  function automatic acc_t tap(halo_t row, int idx);
    return acc_t'(row[$bits(halo_t) - 8 * (idx + 1) +: 8]);
  endfunction

  // Lane i sees halo pixels i .. i+2 of each row
  always_comb begin
    acc_t acc;
    for (int lane = 0; lane < STRIP_PIX; lane++) begin
      acc = acc_t'(KERNEL_ROUND);
      for (int r = 0; r < 3; r++) begin
        for (int c = 0; c < 3; c++) begin
          acc = acc + acc_t'(KERNEL_W[r][c]) * tap(win_rows[r], lane + c);
        end
      end
      blur_strip[STRIP_W - 8 * (lane + 1) +: 8] = pixel_t'(acc >> KERNEL_SHIFT);
    end
  end

endmodule

/* src/gaussian_blur_top.sv */
module gaussian_blur_top #(
  parameter int STRIP_COUNT = 4,
  parameter int IMG_ROWS    = 12
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              start,
  output logic                                              done,
  input  logic [STRIP_COUNT*blur_geom_pkg::STRIP_PIX*8-1:0] img_dout,
  output blur_geom_pkg::row_addr_t                          img_addr,
  input  logic [STRIP_COUNT*blur_geom_pkg::STRIP_PIX*8-1:0] blur_dout,
  output blur_geom_pkg::row_addr_t                          blur_addr_r,
  output logic                                              blur_we,
  output blur_geom_pkg::row_addr_t                          blur_addr_w,
  output logic [STRIP_COUNT*blur_geom_pkg::STRIP_PIX*8-1:0] blur_din
);
  import blur_geom_pkg::*;

  col_t        col;
  logic        win_clear;
  logic        row_shift;
  logic        zero_row;
  logic        rd_valid;
  halo_t [2:0] win_rows;
  strip_t      blur_strip;

  blur_ctrl #(
    .STRIP_COUNT (STRIP_COUNT),
    .IMG_ROWS    (IMG_ROWS)
  ) u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .done        (done),
    .img_addr    (img_addr),
    .col         (col),
    .win_clear   (win_clear),
    .row_shift   (row_shift),
    .zero_row    (zero_row),
    .blur_addr_r (blur_addr_r),
    .rd_valid    (rd_valid)
  );

  row_window #(
    .STRIP_COUNT (STRIP_COUNT)
  ) u_window (
    .clk       (clk),
    .rst_n     (rst_n),
    .img_dout  (img_dout),
    .col       (col),
    .win_clear (win_clear),
    .row_shift (row_shift),
    .zero_row  (zero_row),
    .win_rows  (win_rows)
  );

  gauss3_kernel u_kernel (
    .win_rows   (win_rows),
    .blur_strip (blur_strip)
  );

  strip_merge #(
    .STRIP_COUNT (STRIP_COUNT)
  ) u_merge (
    .clk         (clk),
    .rst_n       (rst_n),
    .col         (col),
    .blur_addr_r (blur_addr_r),
    .rd_valid    (rd_valid),
    .blur_dout   (blur_dout),
    .blur_strip  (blur_strip),
    .blur_we     (blur_we),
    .blur_addr_w (blur_addr_w),
    .blur_din    (blur_din)
  );

endmodule

/* src/row_window.sv */
module row_window #(
  parameter int STRIP_COUNT = 4
) (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [STRIP_COUNT*blur_geom_pkg::STRIP_PIX*8-1:0] img_dout,
  input  blur_geom_pkg::col_t                              col,
  input  logic                                             win_clear,
  input  logic                                             row_shift,
  input  logic                                             zero_row,
  output blur_geom_pkg::halo_t [2:0]                       win_rows
);
  import blur_geom_pkg::*;

  localparam int STRIP_W = $bits(strip_t);
  localparam int ROW_W   = STRIP_COUNT * STRIP_W;
  localparam int PAD_W   = ROW_W + 2 * $bits(pixel_t);

  logic [PAD_W-1:0] padded;
  halo_t            halo;
  halo_t            new_row;

  // Zero pixel beyond the left and right image edges
  assign padded = {pixel_t'(0), img_dout, pixel_t'(0)};

  // Slot 0 is at the top, the halo of strip col begins one pixel before it
  assign halo = padded[(STRIP_COUNT - 1 - int'(col)) * STRIP_W +: $bits(halo_t)];

  assign new_row = zero_row ? '0 : halo;

  // win_rows[0] holds the oldest row, win_rows[2] the newest
  always_ff @(posedge clk) begin
    if (!rst_n || win_clear) begin
      win_rows <= '0;
    end else if (row_shift) begin
      win_rows <= {new_row, win_rows[2:1]};
    end
  end

endmodule

/* src/strip_merge.sv */
module strip_merge #(
  parameter int STRIP_COUNT = 4
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  blur_geom_pkg::col_t                               col,
  input  blur_geom_pkg::row_addr_t                          blur_addr_r,
  input  logic                                              rd_valid,
  input  logic [STRIP_COUNT*blur_geom_pkg::STRIP_PIX*8-1:0] blur_dout,
  input  blur_geom_pkg::strip_t                             blur_strip,
  output logic                                              blur_we,
  output blur_geom_pkg::row_addr_t                          blur_addr_w,
  output logic [STRIP_COUNT*blur_geom_pkg::STRIP_PIX*8-1:0] blur_din
);
  import blur_geom_pkg::*;

  localparam int STRIP_W = $bits(strip_t);
  localparam int ROW_W   = STRIP_COUNT * STRIP_W;

  row_addr_t        addr_d;
  logic             valid_d;
  logic [ROW_W-1:0] merged;

  // Line up with blur_dout, which trails the read address by a cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_d <= 1'b0;
    end else begin
      valid_d <= rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    addr_d <= blur_addr_r;
  end

  // Earlier strips from memory, the new strip in its slot, zeros after it
  always_comb begin
    int base;
    for (int s = 0; s < STRIP_COUNT; s++) begin
      base = ROW_W - STRIP_W * (s + 1);
      if (col_t'(s) < col) begin
        merged[base +: STRIP_W] = blur_dout[base +: STRIP_W];
      end else if (col_t'(s) == col) begin
        merged[base +: STRIP_W] = blur_strip;
      end else begin
        merged[base +: STRIP_W] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_we <= 1'b0;
    end else begin
      blur_we <= valid_d;
    end
  end

  always_ff @(posedge clk) begin
    blur_addr_w <= addr_d;
    blur_din    <= merged;
  end

endmodule

/* test/gaussian_blur_assert.sv */
module gaussian_blur_assert #(
  parameter int IMG_ROWS = 12
) (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     done,
  input blur_geom_pkg::row_addr_t img_addr,
  input logic                     blur_we,
  input blur_geom_pkg::row_addr_t blur_addr_w
);

  // Writes only land on rows of the image
  write_row_in_range: assert property (
    @(posedge clk) disable iff (!rst_n) blur_we |-> int'(blur_addr_w) < IMG_ROWS
  ) else $error("blur write to row %0d outside the image", blur_addr_w);

  read_row_in_range: assert property (
    @(posedge clk) disable iff (!rst_n) int'(img_addr) < IMG_ROWS
  ) else $error("image read of row %0d outside the image", img_addr);

  // All writes are over once done is up
  done_not_with_write: assert property (
    @(posedge clk) disable iff (!rst_n) !(done && blur_we)
  ) else $error("done and blur_we high in the same cycle");

  done_low_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> !done
  ) else $error("done high right after reset");

endmodule

bind gaussian_blur_top gaussian_blur_assert #(
  .IMG_ROWS (IMG_ROWS)
) u_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .done        (done),
  .img_addr    (img_addr),
  .blur_we     (blur_we),
  .blur_addr_w (blur_addr_w)
);

/* test/tb_gaussian_blur.sv */
module tb_gaussian_blur;
  import blur_geom_pkg::*;

  localparam int STRIP_COUNT     = 4;
  localparam int IMG_ROWS        = 12;
  localparam int ROW_W           = STRIP_COUNT * STRIP_PIX * 8;
  localparam int ROW_PIX         = STRIP_COUNT * STRIP_PIX;
  localparam int MEM_DEPTH       = 2 ** $bits(row_addr_t);
  localparam int RUN_WRITES      = STRIP_COUNT * IMG_ROWS;
  localparam int RUN_CYCLES      = STRIP_COUNT * (IMG_ROWS + 5) + 20;
  // Twice the length of three runs plus reset and idle checks
  localparam int WATCHDOG_CYCLES = 2 * (3 * RUN_CYCLES + 20);

  logic             clk = 1'b0;
  logic             rst_n;
  logic             start;
  logic             done;
  logic [ROW_W-1:0] img_dout = '0;
  row_addr_t        img_addr;
  logic [ROW_W-1:0] blur_dout = '0;
  row_addr_t        blur_addr_r;
  logic             blur_we;
  row_addr_t        blur_addr_w;
  logic [ROW_W-1:0] blur_din;

  logic [ROW_W-1:0] img_mem [MEM_DEPTH];
  logic [ROW_W-1:0] blur_mem [MEM_DEPTH];
  int               seed;
  int               write_count = 0;

  gaussian_blur_top #(
    .STRIP_COUNT (STRIP_COUNT),
    .IMG_ROWS    (IMG_ROWS)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .done        (done),
    .img_dout    (img_dout),
    .img_addr    (img_addr),
    .blur_dout   (blur_dout),
    .blur_addr_r (blur_addr_r),
    .blur_we     (blur_we),
    .blur_addr_w (blur_addr_w),
    .blur_din    (blur_din)
  );

  always #2 clk = ~clk;

  // Both SRAMs answer one cycle after the address
  always @(posedge clk) begin
    img_dout  <= img_mem[img_addr];
    blur_dout <= blur_mem[blur_addr_r];
    if (blur_we) begin
      blur_mem[blur_addr_w] <= blur_din;
    end
  end

  task automatic compare_values(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("** Error at %0t: %s: got %0d, expected %0d", $time, what, actual, expected);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  // Zero outside the image
  function automatic int image_pixel(int row, int x);
    if (row < 0 || row >= IMG_ROWS || x < 0 || x >= ROW_PIX) begin
      return 0;
    end
    return int'(img_mem[row_addr_t'(row)][ROW_W - 8 * (x + 1) +: 8]);
  endfunction

  // Per axis the weight is 2 on the centre line and 1 off it
  function automatic int ref_blur(int row, int x);
    int acc;
    int w;
    acc = KERNEL_ROUND;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        w = (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);
        acc = acc + w * image_pixel(row + dr, x + dc);
      end
    end
    return acc >> KERNEL_SHIFT;
  endfunction

  task automatic check_write();
    int n;
    int strip;
    int row;
    int expected;
    n = write_count % RUN_WRITES;
    strip = n / IMG_ROWS;
    row = n % IMG_ROWS;
    compare_values(int'(done), 0, "done high during a write");
    compare_values(int'(blur_addr_w), row, "write row address");
    for (int x = 0; x < ROW_PIX; x++) begin
      expected = (x / STRIP_PIX <= strip) ? ref_blur(row, x) : 0;
      compare_values(int'(blur_din[ROW_W - 8 * (x + 1) +: 8]), expected,
                     $sformatf("strip %0d write, row %0d pixel %0d", strip, row, x));
    end
    write_count++;
  endtask

  always @(negedge clk) begin
    if (rst_n && blur_we) begin
      check_write();
    end
  end

  task automatic check_blur_memory();
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int x = 0; x < ROW_PIX; x++) begin
        compare_values(int'(blur_mem[row_addr_t'(r)][ROW_W - 8 * (x + 1) +: 8]),
                       ref_blur(r, x), $sformatf("blur row %0d pixel %0d", r, x));
      end
    end
  endtask

  // Flat 255 image has 9, 12 or 16 weight units inside
  task automatic check_flat_edges();
    int borders;
    int expected;
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int x = 0; x < ROW_PIX; x++) begin
        borders = int'(r == 0 || r == IMG_ROWS - 1) + int'(x == 0 || x == ROW_PIX - 1);
        expected = (borders == 2) ? 143 : (borders == 1) ? 191 : 255;
        compare_values(int'(blur_mem[row_addr_t'(r)][ROW_W - 8 * (x + 1) +: 8]),
                       expected, $sformatf("flat image row %0d pixel %0d", r, x));
      end
    end
  endtask

  task automatic load_random_image();
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int w = 0; w < ROW_W / 32; w++) begin
        img_mem[row_addr_t'(r)][32 * w +: 32] = $random(seed);
      end
    end
  endtask

  task automatic run_image(input int run_no);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    compare_values(int'(done), 0, "done still high after start");
    // A start in the middle of a run has no effect
    repeat (5) @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (!done) begin
      @(negedge clk);
    end
    compare_values(write_count, run_no * RUN_WRITES, "writes seen when done rose");
    repeat (2) @(negedge clk);
    compare_values(int'(done), 1, "done dropped while idle");
    compare_values(int'(blur_we), 0, "write while idle");
  endtask

  initial begin
    seed = 32'hb94a58d5;
    rst_n = 1'b0;
    start = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    compare_values(int'(done), 0, "done after reset");
    compare_values(int'(blur_we), 0, "blur_we after reset");

    load_random_image();
    run_image(1);
    check_blur_memory();

    for (int r = 0; r < IMG_ROWS; r++) begin
      img_mem[row_addr_t'(r)] = '1;
    end
    run_image(2);
    check_flat_edges();
    check_blur_memory();

    load_random_image();
    run_image(3);
    check_blur_memory();

    $display("Result: PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles and the run did not finish", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $fatal(1);
  end

endmodule
